//--- mipsCore.sv
`timescale 1ns/100ps

module mipsCore (
	input  logic                              clk_i,
	input  logic                              rst_i,
	output logic [mipsIsaPkg::XLEN-1:0]       imemAddr_o,
	input  mipsIsaPkg::instrT                 imemInstr_i,
	output logic                              wbValid_o,
	output logic [mipsIsaPkg::REG_ADDR_W-1:0] wbReg_o,
	output logic [mipsIsaPkg::XLEN-1:0]       wbData_o
);

	logic [mipsIsaPkg::XLEN-1:0] pc;
	logic [mipsIsaPkg::XLEN-1:0] pc4;
	logic [mipsIsaPkg::XLEN-1:0] pcNext;

	logic                        ifIdValid;
	mipsIsaPkg::instrT           ifIdInstr;
	logic [mipsIsaPkg::XLEN-1:0] ifIdPc4;

	mipsPipePkg::ctrlT           decCtrl;
	logic [mipsIsaPkg::XLEN-1:0] decImm;
	logic [mipsIsaPkg::XLEN-1:0] rfDataA;
	logic [mipsIsaPkg::XLEN-1:0] rfDataB;

	mipsPipePkg::idExT           idExNext;
	mipsPipePkg::idExT           idEx;
	mipsPipePkg::exMemT          exMemNext;
	mipsPipePkg::exMemT          exMem;
	mipsPipePkg::memWbT          memWbNext;
	mipsPipePkg::memWbT          memWb;

	logic                        stall;
	logic                        flush;
	mipsPipePkg::fwdSelE         fwdA;
	mipsPipePkg::fwdSelE         fwdB;
	logic [mipsIsaPkg::XLEN-1:0] aluResult;
	logic [mipsIsaPkg::XLEN-1:0] storeData;
	logic                        branchTaken;
	logic [mipsIsaPkg::XLEN-1:0] branchTarget;
	logic [mipsIsaPkg::XLEN-1:0] dmemRData;
	logic [mipsIsaPkg::XLEN-1:0] wbData;
	logic                        rfWe;

	// Fetch
	assign pc4        = pc + mipsIsaPkg::XLEN'(4);
	assign pcNext     = branchTaken ? branchTarget : pc4;
	assign imemAddr_o = pc;

	// PC holds during a load-use stall
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			pc <= '0;
		else if (!stall)
			pc <= pcNext;
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i || flush)
		begin
			ifIdValid <= 1'b0;
			ifIdInstr <= '0;
			ifIdPc4   <= '0;
		end
		else if (!stall)
		begin
			ifIdValid <= 1'b1;
			ifIdInstr <= imemInstr_i;
			ifIdPc4   <= pc4;
		end
	end

	// Decode and register read
	mipsDecoder i_decoder (
		.instr_i (ifIdInstr),
		.ctrl_o  (decCtrl),
		.imm_o   (decImm)
	);

	mipsRegFile i_regFile (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.we_i     (rfWe),
		.wAddr_i  (memWb.dest),
		.wData_i  (wbData),
		.rAddrA_i (ifIdInstr.r.rs),
		.rAddrB_i (ifIdInstr.r.rt),
		.rDataA_o (rfDataA),
		.rDataB_o (rfDataB)
	);

	always_comb
	begin
		idExNext.valid = ifIdValid;
		idExNext.ctrl  = decCtrl;
		idExNext.rs    = ifIdInstr.r.rs;
		idExNext.rt    = ifIdInstr.r.rt;
		// Immediate forms write rt, R-type writes rd
		idExNext.dest  = decCtrl.aluSrcImm ? ifIdInstr.r.rt : ifIdInstr.r.rd;
		idExNext.rsVal = rfDataA;
		idExNext.rtVal = rfDataB;
		idExNext.imm   = decImm;
		idExNext.pc4   = ifIdPc4;
	end

	// Stall and flush both leave a bubble in EX
	always_ff @(posedge clk_i)
	begin
		if (rst_i || flush || stall)
			idEx <= '0;
		else
			idEx <= idExNext;
	end

	mipsHazardUnit i_hazardUnit (
		.idRs_i        (ifIdInstr.r.rs),
		.idRt_i        (ifIdInstr.r.rt),
		.idEx_i        (idEx),
		.exMem_i       (exMem),
		.memWb_i       (memWb),
		.branchTaken_i (branchTaken),
		.stall_o       (stall),
		.flush_o       (flush),
		.fwdA_o        (fwdA),
		.fwdB_o        (fwdB)
	);

	// Execute
	mipsExecute i_execute (
		.idEx_i         (idEx),
		.memFwd_i       (exMem.aluResult),
		.wbFwd_i        (wbData),
		.fwdA_i         (fwdA),
		.fwdB_i         (fwdB),
		.aluResult_o    (aluResult),
		.storeData_o    (storeData),
		.branchTaken_o  (branchTaken),
		.branchTarget_o (branchTarget)
	);

	always_comb
	begin
		exMemNext.valid     = idEx.valid;
		exMemNext.ctrl      = idEx.ctrl;
		exMemNext.dest      = idEx.dest;
		exMemNext.aluResult = aluResult;
		exMemNext.storeData = storeData;
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			exMem <= '0;
		else
			exMem <= exMemNext;
	end

	// Memory access
	mipsDataMem #(
		.DEPTH (mipsPipePkg::DMEM_WORDS)
	) i_dataMem (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.we_i    (exMem.valid && exMem.ctrl.memWrite),
		.addr_i  (exMem.aluResult),
		.wData_i (exMem.storeData),
		.rData_o (dmemRData)
	);

	always_comb
	begin
		memWbNext.valid     = exMem.valid;
		memWbNext.regWrite  = exMem.ctrl.regWrite;
		memWbNext.memToReg  = exMem.ctrl.memToReg;
		memWbNext.dest      = exMem.dest;
		memWbNext.aluResult = exMem.aluResult;
		memWbNext.loadData  = dmemRData;
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			memWb <= '0;
		else
			memWb <= memWbNext;
	end

	// Write-back
	assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;
	assign rfWe   = memWb.valid && memWb.regWrite;

	// r0 writes retire silently
	assign wbValid_o = rfWe && memWb.dest != '0;
	assign wbReg_o   = memWb.dest;
	assign wbData_o  = wbData;

endmodule

//--- mipsDataMem.sv
`timescale 1ns/100ps

module mipsDataMem #(
	parameter int DEPTH = mipsPipePkg::DMEM_WORDS
) (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic                        we_i,
	input  logic [mipsIsaPkg::XLEN-1:0] addr_i,
	input  logic [mipsIsaPkg::XLEN-1:0] wData_i,
	output logic [mipsIsaPkg::XLEN-1:0] rData_o
);

	logic [mipsIsaPkg::XLEN-1:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]    wordIdx;

	// Byte address to word index, wrapping at the depth
	assign wordIdx = addr_i[2 +: $clog2(DEPTH)];

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			mem <= '{default: '0};
		else if (we_i)
			mem[wordIdx] <= wData_i;
	end

	assign rData_o = mem[wordIdx];

endmodule

//--- mipsDecoder.sv
`timescale 1ns/100ps

module mipsDecoder (
	input  mipsIsaPkg::instrT           instr_i,
	output mipsPipePkg::ctrlT           ctrl_o,
	output logic [mipsIsaPkg::XLEN-1:0] imm_o
);

	mipsIsaPkg::opcodeE opcode;
	mipsIsaPkg::functE  funct;

	assign opcode = mipsIsaPkg::opcodeE'(instr_i.r.opcode);
	assign funct  = mipsIsaPkg::functE'(instr_i.r.funct);

	always_comb
	begin
		ctrl_o = '0;
		// Sign extension is the common case
		imm_o  = {{(mipsIsaPkg::XLEN - mipsIsaPkg::IMM_MSB - 1){instr_i.i.imm[mipsIsaPkg::IMM_MSB]}},
			instr_i.i.imm};
		case (opcode)
			mipsIsaPkg::OP_RTYPE:
			begin
				ctrl_o.regWrite = 1'b1;
				case (funct)
					mipsIsaPkg::F_ADD: ctrl_o.aluOp = mipsPipePkg::ALU_ADD;
					mipsIsaPkg::F_SUB: ctrl_o.aluOp = mipsPipePkg::ALU_SUB;
					mipsIsaPkg::F_AND: ctrl_o.aluOp = mipsPipePkg::ALU_AND;
					mipsIsaPkg::F_OR:  ctrl_o.aluOp = mipsPipePkg::ALU_OR;
					mipsIsaPkg::F_SLT: ctrl_o.aluOp = mipsPipePkg::ALU_SLT;
					// Shifts and the rest fall back to a nop
					default:           ctrl_o = '0;
				endcase
			end
			mipsIsaPkg::OP_ADDI:
			begin
				ctrl_o.regWrite  = 1'b1;
				ctrl_o.aluSrcImm = 1'b1;
				ctrl_o.aluOp     = mipsPipePkg::ALU_ADD;
			end
			mipsIsaPkg::OP_ORI:
			begin
				ctrl_o.regWrite  = 1'b1;
				ctrl_o.aluSrcImm = 1'b1;
				ctrl_o.aluOp     = mipsPipePkg::ALU_OR;
				imm_o            = {{(mipsIsaPkg::XLEN - mipsIsaPkg::IMM_MSB - 1){1'b0}},
					instr_i.i.imm};
			end
			mipsIsaPkg::OP_LW:
			begin
				ctrl_o.regWrite  = 1'b1;
				ctrl_o.memRead   = 1'b1;
				ctrl_o.memToReg  = 1'b1;
				ctrl_o.aluSrcImm = 1'b1;
				ctrl_o.aluOp     = mipsPipePkg::ALU_ADD;
			end
			mipsIsaPkg::OP_SW:
			begin
				ctrl_o.memWrite  = 1'b1;
				ctrl_o.aluSrcImm = 1'b1;
				ctrl_o.aluOp     = mipsPipePkg::ALU_ADD;
			end
			mipsIsaPkg::OP_BEQ:
			begin
				ctrl_o.branch = 1'b1;
				ctrl_o.aluOp  = mipsPipePkg::ALU_SUB;
			end
			mipsIsaPkg::OP_BNE:
			begin
				ctrl_o.branch   = 1'b1;
				ctrl_o.branchNe = 1'b1;
				ctrl_o.aluOp    = mipsPipePkg::ALU_SUB;
			end
			default: ctrl_o = '0;
		endcase
	end

endmodule

//--- mipsExecute.sv
`timescale 1ns/100ps

module mipsExecute (
	input  mipsPipePkg::idExT           idEx_i,
	input  logic [mipsIsaPkg::XLEN-1:0] memFwd_i,
	input  logic [mipsIsaPkg::XLEN-1:0] wbFwd_i,
	input  mipsPipePkg::fwdSelE         fwdA_i,
	input  mipsPipePkg::fwdSelE         fwdB_i,
	output logic [mipsIsaPkg::XLEN-1:0] aluResult_o,
	output logic [mipsIsaPkg::XLEN-1:0] storeData_o,
	output logic                        branchTaken_o,
	output logic [mipsIsaPkg::XLEN-1:0] branchTarget_o
);

	logic [mipsIsaPkg::XLEN-1:0] opA;
	logic [mipsIsaPkg::XLEN-1:0] rtFwd;
	logic [mipsIsaPkg::XLEN-1:0] opB;
	logic                        operandsEqual;

	function automatic logic [mipsIsaPkg::XLEN-1:0] fwdMux(
		input mipsPipePkg::fwdSelE         sel,
		input logic [mipsIsaPkg::XLEN-1:0] regVal,
		input logic [mipsIsaPkg::XLEN-1:0] memVal,
		input logic [mipsIsaPkg::XLEN-1:0] wbVal
	);
		case (sel)
			mipsPipePkg::FWD_MEM: return memVal;
			mipsPipePkg::FWD_WB:  return wbVal;
			default:              return regVal;
		endcase
	endfunction

	assign opA   = fwdMux(fwdA_i, idEx_i.rsVal, memFwd_i, wbFwd_i);
	assign rtFwd = fwdMux(fwdB_i, idEx_i.rtVal, memFwd_i, wbFwd_i);
	assign opB   = idEx_i.ctrl.aluSrcImm ? idEx_i.imm : rtFwd;

	// Store data always comes from rt, never the immediate
	assign storeData_o = rtFwd;

	always_comb
	begin
		case (idEx_i.ctrl.aluOp)
			mipsPipePkg::ALU_ADD: aluResult_o = opA + opB;
			mipsPipePkg::ALU_SUB: aluResult_o = opA - opB;
			mipsPipePkg::ALU_AND: aluResult_o = opA & opB;
			mipsPipePkg::ALU_OR:  aluResult_o = opA | opB;
			mipsPipePkg::ALU_SLT:
				aluResult_o = {{(mipsIsaPkg::XLEN - 1){1'b0}}, $signed(opA) < $signed(opB)};
			default:              aluResult_o = '0;
		endcase
	end

	// Branch compares rs against forwarded rt
	assign operandsEqual = (opA == rtFwd);
	assign branchTaken_o = idEx_i.valid && idEx_i.ctrl.branch
		&& (idEx_i.ctrl.branchNe ? !operandsEqual : operandsEqual);

	// Word offset relative to the delay-free pc4
	assign branchTarget_o = idEx_i.pc4 + {idEx_i.imm[mipsIsaPkg::XLEN-3:0], 2'b00};

endmodule

//--- mipsHazardUnit.sv
`timescale 1ns/100ps

module mipsHazardUnit (
	input  logic [mipsIsaPkg::REG_ADDR_W-1:0] idRs_i,
	input  logic [mipsIsaPkg::REG_ADDR_W-1:0] idRt_i,
	input  mipsPipePkg::idExT                 idEx_i,
	input  mipsPipePkg::exMemT                exMem_i,
	input  mipsPipePkg::memWbT                memWb_i,
	input  logic                              branchTaken_i,
	output logic                              stall_o,
	output logic                              flush_o,
	output mipsPipePkg::fwdSelE               fwdA_o,
	output mipsPipePkg::fwdSelE               fwdB_o
);

	logic memWrites;
	logic wbWrites;

	// Producers that will write a nonzero register
	assign memWrites = exMem_i.valid && exMem_i.ctrl.regWrite && exMem_i.dest != '0;
	assign wbWrites  = memWb_i.valid && memWb_i.regWrite && memWb_i.dest != '0;

	// Younger producer in MEM wins over WB
	function automatic mipsPipePkg::fwdSelE selectSrc(
		input logic [mipsIsaPkg::REG_ADDR_W-1:0] src
	);
		if (memWrites && exMem_i.dest == src)
			return mipsPipePkg::FWD_MEM;
		else if (wbWrites && memWb_i.dest == src)
			return mipsPipePkg::FWD_WB;
		else
			return mipsPipePkg::FWD_NONE;
	endfunction

	always_comb
	begin
		fwdA_o = selectSrc(idEx_i.rs);
		fwdB_o = selectSrc(idEx_i.rt);
	end

	// Load result is not ready for the next instruction in EX
	assign stall_o = idEx_i.valid && idEx_i.ctrl.memRead && idEx_i.dest != '0
		&& (idEx_i.dest == idRs_i || idEx_i.dest == idRt_i);

	assign flush_o = branchTaken_i;

endmodule

//--- mipsIsaPkg.sv
package mipsIsaPkg;

	// Data path and register index widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// Instruction field positions
	localparam int OPCODE_MSB = 31;
	localparam int OPCODE_LSB = 26;
	localparam int RS_MSB     = 25;
	localparam int RS_LSB     = 21;
	localparam int RT_MSB     = 20;
	localparam int RT_LSB     = 16;
	localparam int RD_MSB     = 15;
	localparam int RD_LSB     = 11;
	localparam int SHAMT_MSB  = 10;
	localparam int SHAMT_LSB  = 6;
	localparam int FUNCT_MSB  = 5;
	localparam int FUNCT_LSB  = 0;
	localparam int IMM_MSB    = 15;
	localparam int IMM_LSB    = 0;

	// Primary opcodes of the supported subset
	typedef enum logic [OPCODE_MSB:OPCODE_LSB] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_ORI   = 6'h0d,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcodeE;

	// Function codes for R-type
	typedef enum logic [FUNCT_MSB:FUNCT_LSB] {
		F_ADD = 6'h20,
		F_SUB = 6'h22,
		F_AND = 6'h24,
		F_OR  = 6'h25,
		F_SLT = 6'h2a
	} functE;

	// Field bit ranges mirror their position in the word
	typedef struct packed {
		logic [OPCODE_MSB:OPCODE_LSB] opcode;
		logic [RS_MSB:RS_LSB]         rs;
		logic [RT_MSB:RT_LSB]         rt;
		logic [RD_MSB:RD_LSB]         rd;
		logic [SHAMT_MSB:SHAMT_LSB]   shamt;
		logic [FUNCT_MSB:FUNCT_LSB]   funct;
	} rFormatT;

	typedef struct packed {
		logic [OPCODE_MSB:OPCODE_LSB] opcode;
		logic [RS_MSB:RS_LSB]         rs;
		logic [RT_MSB:RT_LSB]         rt;
		logic [IMM_MSB:IMM_LSB]       imm;
	} iFormatT;

	typedef union packed {
		rFormatT          r;
		iFormatT          i;
		logic [XLEN-1:0]  word;
	} instrT;

endpackage

//--- mipsPipePkg.sv
package mipsPipePkg;

	// Default data memory depth in words
	localparam int DMEM_WORDS = 64;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} aluOpE;

	// Operand source for the EX stage
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1,
		FWD_WB   = 2'd2
	} fwdSelE;

	// All-zero bundle is a nop
	typedef struct packed {
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  aluSrcImm;
		logic  branch;
		logic  branchNe;
		aluOpE aluOp;
	} ctrlT;

	typedef struct packed {
		logic                                  valid;
		ctrlT                                  ctrl;
		logic [mipsIsaPkg::REG_ADDR_W-1:0]     rs;
		logic [mipsIsaPkg::REG_ADDR_W-1:0]     rt;
		logic [mipsIsaPkg::REG_ADDR_W-1:0]     dest;
		logic [mipsIsaPkg::XLEN-1:0]           rsVal;
		logic [mipsIsaPkg::XLEN-1:0]           rtVal;
		logic [mipsIsaPkg::XLEN-1:0]           imm;
		// Needed for the branch target in EX
		logic [mipsIsaPkg::XLEN-1:0]           pc4;
	} idExT;

	typedef struct packed {
		logic                                  valid;
		ctrlT                                  ctrl;
		logic [mipsIsaPkg::REG_ADDR_W-1:0]     dest;
		logic [mipsIsaPkg::XLEN-1:0]           aluResult;
		logic [mipsIsaPkg::XLEN-1:0]           storeData;
	} exMemT;

	typedef struct packed {
		logic                                  valid;
		logic                                  regWrite;
		logic                                  memToReg;
		logic [mipsIsaPkg::REG_ADDR_W-1:0]     dest;
		logic [mipsIsaPkg::XLEN-1:0]           aluResult;
		logic [mipsIsaPkg::XLEN-1:0]           loadData;
	} memWbT;

endpackage

//--- mipsRegFile.sv
`timescale 1ns/100ps

module mipsRegFile (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  logic                                we_i,
	input  logic [mipsIsaPkg::REG_ADDR_W-1:0]   wAddr_i,
	input  logic [mipsIsaPkg::XLEN-1:0]         wData_i,
	input  logic [mipsIsaPkg::REG_ADDR_W-1:0]   rAddrA_i,
	input  logic [mipsIsaPkg::REG_ADDR_W-1:0]   rAddrB_i,
	output logic [mipsIsaPkg::XLEN-1:0]         rDataA_o,
	output logic [mipsIsaPkg::XLEN-1:0]         rDataB_o
);

	logic [mipsIsaPkg::XLEN-1:0] regs [2**mipsIsaPkg::REG_ADDR_W];

	// r0 is never written so it reads as zero
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			regs <= '{default: '0};
		else if (we_i && wAddr_i != '0)
			regs[wAddr_i] <= wData_i;
	end

	// Write-first bypass for a same-cycle WB
	assign rDataA_o = (we_i && wAddr_i != '0 && wAddr_i == rAddrA_i) ? wData_i : regs[rAddrA_i];
	assign rDataB_o = (we_i && wAddr_i != '0 && wAddr_i == rAddrB_i) ? wData_i : regs[rAddrB_i];

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing -f sim.f --top-module tbMips -o tbMips > build.log 2>&1 \
	&& ./obj_dir/tbMips > sim.log 2>&1 \
	&& grep -q "^Result: PASSED$" sim.log \
	&& echo "Simulation passed, see sim.log" \
	|| { echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- sim.f
+incdir+.
mipsIsaPkg.sv
mipsPipePkg.sv
mipsDecoder.sv
mipsRegFile.sv
mipsHazardUnit.sv
mipsExecute.sv
mipsDataMem.sv
mipsCore.sv
tbMips.sv

//--- tbPrograms.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic logic [31:0] encR(input int rd, input int rs, input int rt,
	input mipsIsaPkg::functE fn);
	return {6'(mipsIsaPkg::OP_RTYPE), 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'(fn)};
endfunction

function automatic logic [31:0] encI(input mipsIsaPkg::opcodeE op, input int rs,
	input int rt, input int imm);
	return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
endfunction

// Branch to itself ends every program
function automatic logic [31:0] haltWord();
	return encI(mipsIsaPkg::OP_BEQ, 0, 0, -1);
endfunction

task automatic clearRom();
	rom = '{default: '0};
	romLen = '0;
endtask

task automatic emit(input logic [31:0] word);
	rom[romLen] = word;
	romLen = romLen + 6'd1;
endtask

// Consumers at distance one, two and three from their producers
task automatic aluChainProgram();
	clearRom();
	emit(encI(mipsIsaPkg::OP_ADDI, 0, 1, 5));
	emit(encI(mipsIsaPkg::OP_ORI, 1, 2, 'hf0f0));
	emit(encR(3, 2, 1, mipsIsaPkg::F_ADD));
	emit(encR(4, 3, 1, mipsIsaPkg::F_SUB));
	emit(encR(5, 4, 2, mipsIsaPkg::F_AND));
	emit(encR(6, 5, 4, mipsIsaPkg::F_OR));
	emit(encI(mipsIsaPkg::OP_ADDI, 6, 7, -300));
	emit(encR(8, 7, 1, mipsIsaPkg::F_SLT));
	emit(encR(9, 1, 7, mipsIsaPkg::F_SLT));
	emit(haltWord());
endtask

task automatic memoryProgram();
	clearRom();
	emit(encI(mipsIsaPkg::OP_ADDI, 0, 1, 'h1234));
	emit(encI(mipsIsaPkg::OP_ADDI, 0, 2, 8));
	emit(encI(mipsIsaPkg::OP_SW, 2, 1, 4));
	emit(encI(mipsIsaPkg::OP_LW, 2, 3, 4));
	// Load-use pair
	emit(encR(4, 3, 1, mipsIsaPkg::F_ADD));
	emit(encI(mipsIsaPkg::OP_SW, 2, 4, -4));
	emit(encI(mipsIsaPkg::OP_LW, 0, 5, 4));
	emit(encR(6, 5, 5, mipsIsaPkg::F_ADD));
	emit(encR(7, 6, 3, mipsIsaPkg::F_OR));
	emit(haltWord());
endtask

// Loop of four, a beq not taken, then a beq over two instructions
task automatic branchProgram();
	clearRom();
	emit(encI(mipsIsaPkg::OP_ADDI, 0, 1, 4));
	emit(encI(mipsIsaPkg::OP_ADDI, 0, 2, 0));
	emit(encR(2, 2, 1, mipsIsaPkg::F_ADD));
	emit(encI(mipsIsaPkg::OP_ADDI, 1, 1, -1));
	emit(encI(mipsIsaPkg::OP_BNE, 1, 0, -3));
	emit(encI(mipsIsaPkg::OP_BEQ, 1, 2, 2));
	emit(encI(mipsIsaPkg::OP_BEQ, 0, 0, 2));
	emit(encI(mipsIsaPkg::OP_ADDI, 0, 3, 99));
	emit(encI(mipsIsaPkg::OP_ADDI, 0, 4, 77));
	emit(encI(mipsIsaPkg::OP_ADDI, 2, 5, 1));
	emit(haltWord());
endtask

task automatic zeroRegProgram();
	clearRom();
	emit(encI(mipsIsaPkg::OP_ADDI, 0, 0, 55));
	emit(encI(mipsIsaPkg::OP_ORI, 0, 1, 7));
	emit(encR(0, 1, 1, mipsIsaPkg::F_ADD));
	emit(encR(2, 0, 1, mipsIsaPkg::F_ADD));
	emit(encI(mipsIsaPkg::OP_SW, 0, 1, 0));
	emit(encI(mipsIsaPkg::OP_LW, 0, 0, 0));
	emit(encR(3, 0, 2, mipsIsaPkg::F_OR));
	emit(haltWord());
endtask

`endif

//--- tbMips.sv
`timescale 1ns/100ps

module tbMips;

	localparam int RST_CYCLES     = 8;
	localparam int TAIL_CYCLES    = 20;
	localparam int ROM_WORDS      = 64;
	localparam int MODEL_STEP_MAX = 2000;
	localparam int RANDOM_LEN     = 40;

	logic        clk;
	logic        rst;
	logic [31:0] imemAddr;
	logic [31:0] imemInstr;
	logic        wbValid;
	logic [4:0]  wbReg;
	logic [31:0] wbData;

	logic [31:0] rom [ROM_WORDS];
	logic [5:0]  romLen;
	logic [15:0] lfsr;
	logic        rstTaken;

	logic [4:0]  expReg [$];
	logic [31:0] expData [$];
	string       testName;
	int          cycleCount;
	int          cycleLimit;
	int          errValue;
	int          errUnexpected;
	int          errReset;
	int          errFetch;

	`include "tbPrograms.svh"

	mipsCore i_dut (
		.clk_i       (clk),
		.rst_i       (rst),
		.imemAddr_o  (imemAddr),
		.imemInstr_i (imemInstr),
		.wbValid_o   (wbValid),
		.wbReg_o     (wbReg),
		.wbData_o    (wbData)
	);

	// Instruction ROM answers in the same cycle
	assign imemInstr = rom[imemAddr[7:2]];

	always #5 clk = ~clk;

	function automatic logic lfsrBit();
		logic outBit;
		outBit = lfsr[0];
		lfsr = lfsr >> 1;
		if (outBit)
			lfsr = lfsr ^ 16'hb400;
		return outBit;
	endfunction

	function automatic int takeBits(input int width);
		int value;
		int k;
		value = 0;
		for (k = 0; k < width; k++)
			value = (value << 1) | {31'd0, lfsrBit()};
		return value;
	endfunction

	// ISA model that fills the expected write-back list and returns its step count
	function automatic int runModel();
		logic [31:0] regs [32];
		logic [31:0] dmem [64];
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sImm;
		logic [31:0] addr;
		logic [31:0] res;
		logic [4:0]  dst;
		logic        wr;
		int          steps;
		regs = '{default: '0};
		dmem = '{default: '0};
		expReg.delete();
		expData.delete();
		pc = '0;
		steps = 0;
		while (rom[pc[7:2]] != haltWord() && steps < MODEL_STEP_MAX)
		begin
			ins  = rom[pc[7:2]];
			a    = regs[ins[25:21]];
			b    = regs[ins[20:16]];
			sImm = {{16{ins[15]}}, ins[15:0]};
			addr = a + sImm;
			dst  = ins[20:16];
			wr   = 1'b1;
			res  = '0;
			pc   = pc + 32'd4;
			case (ins[31:26])
				6'h00:
				begin
					dst = ins[15:11];
					case (ins[5:0])
						6'h20: res = a + b;
						6'h22: res = a - b;
						6'h24: res = a & b;
						6'h25: res = a | b;
						6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				6'h08: res = a + sImm;
				6'h0d: res = a | {16'd0, ins[15:0]};
				6'h23: res = dmem[addr[7:2]];
				6'h2b:
				begin
					dmem[addr[7:2]] = b;
					wr = 1'b0;
				end
				6'h04:
				begin
					if (a == b)
						pc = pc + {sImm[29:0], 2'b00};
					wr = 1'b0;
				end
				6'h05:
				begin
					if (a != b)
						pc = pc + {sImm[29:0], 2'b00};
					wr = 1'b0;
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0)
			begin
				regs[dst] = res;
				expReg.push_back(dst);
				expData.push_back(res);
			end
			steps++;
		end
		return steps;
	endfunction

	// Straight-line mix of ALU ops and word accesses to eight addresses
	task automatic randomProgram();
		int kind;
		int rd;
		int rs;
		int rt;
		int imm;
		int n;
		clearRom();
		for (n = 0; n < RANDOM_LEN; n++)
		begin
			kind = takeBits(4) % 9;
			rd   = takeBits(3);
			rs   = takeBits(3);
			rt   = takeBits(3);
			imm  = takeBits(16);
			case (kind)
				0: emit(encR(rd, rs, rt, mipsIsaPkg::F_ADD));
				1: emit(encR(rd, rs, rt, mipsIsaPkg::F_SUB));
				2: emit(encR(rd, rs, rt, mipsIsaPkg::F_AND));
				3: emit(encR(rd, rs, rt, mipsIsaPkg::F_OR));
				4: emit(encR(rd, rs, rt, mipsIsaPkg::F_SLT));
				5: emit(encI(mipsIsaPkg::OP_ADDI, rs, rd, imm));
				6: emit(encI(mipsIsaPkg::OP_ORI, rs, rd, imm));
				7: emit(encI(mipsIsaPkg::OP_LW, 0, rd, 4 * rt));
				default: emit(encI(mipsIsaPkg::OP_SW, 0, rs, 4 * rt));
			endcase
		end
		emit(haltWord());
	endtask

	task automatic assertReset();
		@(posedge clk);
		#1;
		rst = 1'b1;
	endtask

	// Expects reset held and the ROM loaded
	task automatic runProgram(input string name, input int abortAfter);
		int steps;
		testName = name;
		steps = runModel();
		cycleLimit = cycleLimit + 3 * steps + 40;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		if (abortAfter > 0)
			repeat (abortAfter) @(posedge clk);
		else
		begin
			while (expReg.size() != 0)
				@(posedge clk);
			repeat (TAIL_CYCLES) @(posedge clk);
		end
	endtask

	always @(posedge clk)
		rstTaken <= rst;

	// Retirement checker sampled mid-cycle
	always @(negedge clk)
	begin
		if (rstTaken && wbValid)
		begin
			errReset++;
			$display("Write-back to r%0d while reset was held in %s", wbReg, testName);
		end
		else if (!rst && wbValid)
		begin
			if (expReg.size() == 0)
			begin
				errUnexpected++;
				$display("Unexpected write-back in %s to r%0d with %h", testName, wbReg, wbData);
			end
			else
			begin
				if (wbReg !== expReg[0])
				begin
					errValue++;
					$display("ERR %s reg expected r%0d actual r%0d", testName, expReg[0], wbReg);
				end
				if (wbData !== expData[0])
				begin
					errValue++;
					$display("ERR %s data expected %h actual %h", testName, expData[0], wbData);
				end
				void'(expReg.pop_front());
				void'(expData.pop_front());
			end
		end
		// Fetches stay word aligned inside the instruction ROM
		if (imemAddr[31:8] !== 24'd0 || imemAddr[1:0] !== 2'b00)
		begin
			errFetch++;
			$display("Fetch address %h lies outside the instruction ROM in %s",
				imemAddr, testName);
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout in %s after %0d cycles", testName, cycleCount);
			$display("Errors: %0d wrong values, %0d unexpected write-backs, %0d during reset, %0d bad fetches",
				errValue, errUnexpected, errReset, errFetch);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial
	begin
		clk           = 1'b0;
		rst           = 1'b1;
		lfsr          = 16'd78;
		cycleCount    = 0;
		cycleLimit    = 0;
		errValue      = 0;
		errUnexpected = 0;
		errReset      = 0;
		errFetch      = 0;
		aluChainProgram();
		runProgram("aluChain", 0);
		assertReset();
		memoryProgram();
		runProgram("storeLoad", 0);
		assertReset();
		branchProgram();
		runProgram("branchLoop", 0);
		assertReset();
		zeroRegProgram();
		runProgram("regZero", 0);
		// Cut short by a second reset and run again from address 0
		assertReset();
		branchProgram();
		runProgram("resetMid", 12);
		assertReset();
		runProgram("resetRerun", 0);
		assertReset();
		randomProgram();
		runProgram("random", 0);
		$display("Errors: %0d wrong values, %0d unexpected write-backs, %0d during reset, %0d bad fetches",
			errValue, errUnexpected, errReset, errFetch);
		if (errValue + errUnexpected + errReset + errFetch == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
